// File: Makefile
VERILATOR ?= verilator
TOP       ?= rv_exec_tb
FLIST     ?= rv_exec_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= Everything OK

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: hw/commit_stage.sv
`timescale 1ns/1ps

module commit_stage (
	input  logic                          clk,
	input  logic                          reset,
	ex_cm_if.dst                          cm,
	fwd_if.src                            fwd,
	output logic                          rf_we,
	output rv_isa_pkg::reg_idx_t          rf_wa,
	output logic [rv_alu_pkg::REG_W-1:0]  rf_wd,
	output logic                          ret_valid,
	output rv_isa_pkg::reg_idx_t          ret_rd,
	output logic                          ret_wen,
	output logic [rv_alu_pkg::REG_W-1:0]  ret_data,
	output logic                          ret_taken,
	output logic [rv_alu_pkg::REG_W-1:0]  ret_target
);

	logic                          me_taken;
	logic [rv_alu_pkg::REG_W-1:0]  me_target;
	logic                          wb_taken;
	logic [rv_alu_pkg::REG_W-1:0]  wb_target;

	// The forwarding fields are the EX/MEM and MEM/WB registers themselves.
	always_ff @(posedge clk) begin
		if (reset) begin
			fwd.me_valid <= 1'b0;
			fwd.me_wen   <= 1'b0;
			fwd.wb_valid <= 1'b0;
			fwd.wb_wen   <= 1'b0;
		end else begin
			fwd.me_valid <= cm.valid;
			fwd.me_wen   <= cm.wen;
			fwd.wb_valid <= fwd.me_valid;
			fwd.wb_wen   <= fwd.me_wen;
		end
	end

	always_ff @(posedge clk) begin
		fwd.me_rd         <= cm.rd;
		fwd.me_alu_result <= cm.alu_result;
		me_taken          <= cm.taken;
		me_target         <= cm.target;
		fwd.wb_rd         <= fwd.me_rd;
		fwd.wb_rd_data    <= fwd.me_alu_result;
		wb_taken          <= me_taken;
		wb_target         <= me_target;
	end

	// Writeback lands in the register file at the end of the retire cycle.
	assign rf_we      = fwd.wb_wen;
	assign rf_wa      = fwd.wb_rd;
	assign rf_wd      = fwd.wb_rd_data;
	assign ret_valid  = fwd.wb_valid;
	assign ret_rd     = fwd.wb_rd;
	assign ret_wen    = fwd.wb_wen;
	assign ret_data   = fwd.wb_rd_data;
	assign ret_taken  = wb_taken;
	assign ret_target = wb_target;

endmodule

// File: hw/exe_stage.sv
`timescale 1ns/1ps

module exe_stage (
	id_ex_if.dst  ex,
	fwd_if.dat    fwd,
	ex_cm_if.src  cm
);

	localparam int W = rv_alu_pkg::REG_W;

	logic [W-1:0]  rs1_fwd;
	logic [W-1:0]  rs2_fwd;
	logic [W-1:0]  op1;
	logic [W-1:0]  op2;
	logic          sub_mode;
	logic [W-1:0]  add_b;
	logic [W:0]    sum_full;
	logic [W-1:0]  sum;
	logic          zero;
	logic          lt;
	logic          ltu;
	logic [W-1:0]  sra_res;
	logic [31:0]   sllw_res;
	logic [31:0]   srlw_res;
	logic [31:0]   sraw_res;
	logic          b_flag;
	logic [W-1:0]  pc_base;
	logic [W-1:0]  target_sum;

	function automatic logic [W-1:0] sext32(input logic [31:0] w);
		return {{(W-32){w[31]}}, w};
	endfunction

	function automatic logic [W-1:0] pick_fwd(input rv_alu_pkg::fwd_src_e sel,
		input logic [W-1:0] rf_val, input logic [W-1:0] me_val, input logic [W-1:0] wb_val);
		case (sel)
			rv_alu_pkg::FWD_ME: return me_val;
			rv_alu_pkg::FWD_WB: return wb_val;
			default: return rf_val;
		endcase
	endfunction

	assign rs1_fwd = pick_fwd(ex.rs1_src, ex.rs1_data, fwd.me_alu_result, fwd.wb_rd_data);
	assign rs2_fwd = pick_fwd(ex.rs2_src, ex.rs2_data, fwd.me_alu_result, fwd.wb_rd_data);

	assign op1 = (ex.op1_src == rv_alu_pkg::OP1_PC) ? ex.pc : rs1_fwd;
	always_comb begin
		case (ex.op2_src)
			rv_alu_pkg::OP2_IMM:  op2 = ex.imm;
			rv_alu_pkg::OP2_FOUR: op2 = W'(4);
			default:              op2 = rs2_fwd;
		endcase
	end

	// Subtraction, compares and branches use op1 + ~op2 + 1.
	assign sub_mode = ex.alu_op inside {rv_alu_pkg::ALU_SUB, rv_alu_pkg::ALU_SUBW,
		rv_alu_pkg::ALU_SLT, rv_alu_pkg::ALU_SLTU, rv_alu_pkg::ALU_BEQ, rv_alu_pkg::ALU_BNE,
		rv_alu_pkg::ALU_BLT, rv_alu_pkg::ALU_BGE, rv_alu_pkg::ALU_BLTU, rv_alu_pkg::ALU_BGEU};
	assign add_b    = sub_mode ? ~op2 : op2;
	assign sum_full = {1'b0, op1} + {1'b0, add_b} + {{W{1'b0}}, sub_mode};
	assign sum      = sum_full[W-1:0];
	assign zero     = (sum == '0);
	// Signed less-than is the sign bit corrected for overflow.
	assign lt       = sum[W-1] ^ ((op1[W-1] == add_b[W-1]) && (sum[W-1] != op1[W-1]));
	// No carry out of the subtraction means op1 is below op2.
	assign ltu      = ~sum_full[W];

	assign sra_res  = $signed(op1) >>> op2[5:0];
	assign sllw_res = op1[31:0] << op2[4:0];
	assign srlw_res = op1[31:0] >> op2[4:0];
	assign sraw_res = $signed(op1[31:0]) >>> op2[4:0];

	always_comb begin
		case (ex.alu_op)
			rv_alu_pkg::ALU_ADD, rv_alu_pkg::ALU_SUB:   cm.alu_result = sum;
			rv_alu_pkg::ALU_ADDW, rv_alu_pkg::ALU_SUBW: cm.alu_result = sext32(sum[31:0]);
			rv_alu_pkg::ALU_SLT:  cm.alu_result = {{(W-1){1'b0}}, lt};
			rv_alu_pkg::ALU_SLTU: cm.alu_result = {{(W-1){1'b0}}, ltu};
			rv_alu_pkg::ALU_XOR:  cm.alu_result = op1 ^ op2;
			rv_alu_pkg::ALU_OR:   cm.alu_result = op1 | op2;
			rv_alu_pkg::ALU_AND:  cm.alu_result = op1 & op2;
			rv_alu_pkg::ALU_SLL:  cm.alu_result = op1 << op2[5:0];
			rv_alu_pkg::ALU_SRL:  cm.alu_result = op1 >> op2[5:0];
			rv_alu_pkg::ALU_SRA:  cm.alu_result = sra_res;
			rv_alu_pkg::ALU_SLLW: cm.alu_result = sext32(sllw_res);
			rv_alu_pkg::ALU_SRLW: cm.alu_result = sext32(srlw_res);
			rv_alu_pkg::ALU_SRAW: cm.alu_result = sext32(sraw_res);
			rv_alu_pkg::ALU_LUI:  cm.alu_result = op2;
			default:              cm.alu_result = '0;
		endcase
	end

	always_comb begin
		case (ex.alu_op)
			rv_alu_pkg::ALU_BEQ:  b_flag = zero;
			rv_alu_pkg::ALU_BNE:  b_flag = ~zero;
			rv_alu_pkg::ALU_BLT:  b_flag = lt;
			rv_alu_pkg::ALU_BGE:  b_flag = ~lt;
			rv_alu_pkg::ALU_BLTU: b_flag = ltu;
			rv_alu_pkg::ALU_BGEU: b_flag = ~ltu;
			default:              b_flag = 1'b0;
		endcase
	end

	// JALR jumps relative to rs1 and drops bit 0 of the target.
	assign pc_base    = ex.pc_src ? rs1_fwd : ex.pc;
	assign target_sum = pc_base + ex.imm;

	assign cm.valid  = ex.valid;
	assign cm.rd     = ex.rd;
	assign cm.wen    = ex.wen;
	assign cm.taken  = b_flag | ex.is_jump;
	assign cm.target = {target_sum[W-1:1], target_sum[0] & ~ex.pc_src};

endmodule

// File: hw/id_stage.sv
`timescale 1ns/1ps

module id_stage (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          in_valid,
	input  rv_isa_pkg::instr_u            in_instr,
	input  logic [rv_alu_pkg::REG_W-1:0]  in_pc,
	output rv_isa_pkg::reg_idx_t          rs1,
	output rv_isa_pkg::reg_idx_t          rs2,
	input  logic [rv_alu_pkg::REG_W-1:0]  rs1_data,
	input  logic [rv_alu_pkg::REG_W-1:0]  rs2_data,
	id_ex_if.src                          ex,
	fwd_if.ctl                            fwd
);

	logic [6:0]                    opcode;
	logic [2:0]                    funct3;
	logic                          alt;
	logic [rv_alu_pkg::REG_W-1:0]  imm_i;
	logic [rv_alu_pkg::REG_W-1:0]  imm_b;
	logic [rv_alu_pkg::REG_W-1:0]  imm_u;
	logic [rv_alu_pkg::REG_W-1:0]  imm_j;

	rv_alu_pkg::alu_op_e           dec_alu_op;
	rv_alu_pkg::op1_src_e          dec_op1_src;
	rv_alu_pkg::op2_src_e          dec_op2_src;
	logic [rv_alu_pkg::REG_W-1:0]  dec_imm;
	logic                          dec_wen;
	logic                          dec_pc_src;
	logic                          dec_is_jump;
	rv_alu_pkg::fwd_src_e          rs1_src;
	rv_alu_pkg::fwd_src_e          rs2_src;

	assign opcode = in_instr.r.opcode;
	assign funct3 = in_instr.r.funct3;
	// Bit 30 picks SUB and the arithmetic right shifts.
	assign alt    = in_instr.r.funct7[5];
	assign rs1    = in_instr.r.rs1;
	assign rs2    = in_instr.r.rs2;

	assign imm_i = {{52{in_instr.i.imm[11]}}, in_instr.i.imm};
	assign imm_b = {{51{in_instr.b.imm12}}, in_instr.b.imm12, in_instr.b.imm11,
		in_instr.b.imm10_5, in_instr.b.imm4_1, 1'b0};
	assign imm_u = {{32{in_instr.u.imm[19]}}, in_instr.u.imm, 12'b0};
	assign imm_j = {{43{in_instr.j.imm20}}, in_instr.j.imm20, in_instr.j.imm19_12,
		in_instr.j.imm11, in_instr.j.imm10_1, 1'b0};

	always_comb begin
		dec_alu_op  = rv_alu_pkg::ALU_ADD;
		dec_op1_src = rv_alu_pkg::OP1_RS1;
		dec_op2_src = rv_alu_pkg::OP2_RS2;
		dec_imm     = imm_i;
		dec_wen     = 1'b0;
		dec_pc_src  = 1'b0;
		dec_is_jump = 1'b0;
		case (opcode)
			rv_isa_pkg::OPC_OP, rv_isa_pkg::OPC_OP_IMM: begin
				dec_wen = 1'b1;
				if (opcode == rv_isa_pkg::OPC_OP_IMM) begin
					dec_op2_src = rv_alu_pkg::OP2_IMM;
				end
				case (funct3)
					3'd0: dec_alu_op = (alt && opcode == rv_isa_pkg::OPC_OP) ?
						rv_alu_pkg::ALU_SUB : rv_alu_pkg::ALU_ADD;
					3'd1: dec_alu_op = rv_alu_pkg::ALU_SLL;
					3'd2: dec_alu_op = rv_alu_pkg::ALU_SLT;
					3'd3: dec_alu_op = rv_alu_pkg::ALU_SLTU;
					3'd4: dec_alu_op = rv_alu_pkg::ALU_XOR;
					3'd5: dec_alu_op = alt ? rv_alu_pkg::ALU_SRA : rv_alu_pkg::ALU_SRL;
					3'd6: dec_alu_op = rv_alu_pkg::ALU_OR;
					default: dec_alu_op = rv_alu_pkg::ALU_AND;
				endcase
			end
			rv_isa_pkg::OPC_OP_32, rv_isa_pkg::OPC_OP_IMM_32: begin
				if (opcode == rv_isa_pkg::OPC_OP_IMM_32) begin
					dec_op2_src = rv_alu_pkg::OP2_IMM;
				end
				dec_wen = 1'b1;
				case (funct3)
					3'd0: dec_alu_op = (alt && opcode == rv_isa_pkg::OPC_OP_32) ?
						rv_alu_pkg::ALU_SUBW : rv_alu_pkg::ALU_ADDW;
					3'd1: dec_alu_op = rv_alu_pkg::ALU_SLLW;
					3'd5: dec_alu_op = alt ? rv_alu_pkg::ALU_SRAW : rv_alu_pkg::ALU_SRLW;
					default: dec_wen = 1'b0;
				endcase
			end
			rv_isa_pkg::OPC_LUI: begin
				dec_alu_op  = rv_alu_pkg::ALU_LUI;
				dec_op2_src = rv_alu_pkg::OP2_IMM;
				dec_imm     = imm_u;
				dec_wen     = 1'b1;
			end
			rv_isa_pkg::OPC_AUIPC: begin
				dec_op1_src = rv_alu_pkg::OP1_PC;
				dec_op2_src = rv_alu_pkg::OP2_IMM;
				dec_imm     = imm_u;
				dec_wen     = 1'b1;
			end
			rv_isa_pkg::OPC_BRANCH: begin
				dec_imm = imm_b;
				case (funct3)
					3'd0: dec_alu_op = rv_alu_pkg::ALU_BEQ;
					3'd1: dec_alu_op = rv_alu_pkg::ALU_BNE;
					3'd4: dec_alu_op = rv_alu_pkg::ALU_BLT;
					3'd5: dec_alu_op = rv_alu_pkg::ALU_BGE;
					3'd6: dec_alu_op = rv_alu_pkg::ALU_BLTU;
					3'd7: dec_alu_op = rv_alu_pkg::ALU_BGEU;
					default: dec_alu_op = rv_alu_pkg::ALU_ADD;
				endcase
			end
			rv_isa_pkg::OPC_JAL, rv_isa_pkg::OPC_JALR: begin
				// Jumps write the link address pc + 4 through the ALU.
				dec_op1_src = rv_alu_pkg::OP1_PC;
				dec_op2_src = rv_alu_pkg::OP2_FOUR;
				dec_imm     = (opcode == rv_isa_pkg::OPC_JAL) ? imm_j : imm_i;
				dec_pc_src  = (opcode == rv_isa_pkg::OPC_JALR);
				dec_is_jump = 1'b1;
				dec_wen     = 1'b1;
			end
			default: dec_wen = 1'b0;
		endcase
	end

	// The ID/EX occupant will sit in EX/MEM when this one executes, hence ME.
	assign rs1_src = (ex.wen && ex.rd == rs1) ? rv_alu_pkg::FWD_ME :
		(fwd.me_wen && fwd.me_rd == rs1) ? rv_alu_pkg::FWD_WB : rv_alu_pkg::FWD_RF;
	assign rs2_src = (ex.wen && ex.rd == rs2) ? rv_alu_pkg::FWD_ME :
		(fwd.me_wen && fwd.me_rd == rs2) ? rv_alu_pkg::FWD_WB : rv_alu_pkg::FWD_RF;

	always_ff @(posedge clk) begin
		if (reset) begin
			ex.valid <= 1'b0;
			ex.wen   <= 1'b0;
		end else begin
			ex.valid <= in_valid;
			ex.wen   <= in_valid && dec_wen && in_instr.r.rd != '0;
		end
	end

	always_ff @(posedge clk) begin
		ex.pc       <= in_pc;
		ex.imm      <= dec_imm;
		ex.rs1_data <= rs1_data;
		ex.rs2_data <= rs2_data;
		ex.rs1_src  <= rs1_src;
		ex.rs2_src  <= rs2_src;
		ex.op1_src  <= dec_op1_src;
		ex.op2_src  <= dec_op2_src;
		ex.alu_op   <= dec_alu_op;
		ex.pc_src   <= dec_pc_src;
		ex.is_jump  <= dec_is_jump;
		ex.rd       <= in_instr.r.rd;
	end

endmodule

// File: hw/regfile.sv
`timescale 1ns/1ps

module regfile (
	input  logic                          clk,
	input  logic                          reset,
	input  rv_isa_pkg::reg_idx_t          rs1,
	input  rv_isa_pkg::reg_idx_t          rs2,
	output logic [rv_alu_pkg::REG_W-1:0]  rs1_data,
	output logic [rv_alu_pkg::REG_W-1:0]  rs2_data,
	input  logic                          we,
	input  rv_isa_pkg::reg_idx_t          wa,
	input  logic [rv_alu_pkg::REG_W-1:0]  wd
);

	// Only x1 to x31 have storage.
	logic [rv_alu_pkg::REG_W-1:0] regs [1:31];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wa != '0) begin
			regs[wa] <= wd;
		end
	end

	// A read of the register being written returns the new value.
	assign rs1_data = (rs1 == '0) ? '0 : (we && wa == rs1) ? wd : regs[rs1];
	assign rs2_data = (rs2 == '0) ? '0 : (we && wa == rs2) ? wd : regs[rs2];

endmodule

// File: hw/rv_alu_pkg.sv
package rv_alu_pkg;

	// Width of the data path and of the pc.
	localparam int REG_W = 64;

	// ALU operations. Code zero is left unused.
	typedef enum logic [4:0] {
		ALU_ADD = 5'd1,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_OR,
		ALU_AND,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_SUB,
		ALU_LUI,
		ALU_BEQ,
		ALU_BNE,
		ALU_BLT,
		ALU_BGE,
		ALU_BLTU,
		ALU_BGEU,
		ALU_ADDW,
		ALU_SUBW,
		ALU_SLLW,
		ALU_SRLW,
		ALU_SRAW
	} alu_op_e;

	// Where a source operand is taken from in the execute stage.
	typedef enum logic [1:0] {
		FWD_RF = 2'd0,
		FWD_ME = 2'd1,
		FWD_WB = 2'd2
	} fwd_src_e;

	typedef enum logic {
		OP1_RS1 = 1'b0,
		OP1_PC  = 1'b1
	} op1_src_e;

	typedef enum logic [1:0] {
		OP2_RS2  = 2'd0,
		OP2_IMM  = 2'd1,
		OP2_FOUR = 2'd2
	} op2_src_e;

endpackage

// File: hw/rv_exec_if.sv
`timescale 1ns/1ps

// ID/EX pipeline register contents.
interface id_ex_if;
	logic                          valid;
	logic [rv_alu_pkg::REG_W-1:0]  pc;
	logic [rv_alu_pkg::REG_W-1:0]  imm;
	logic [rv_alu_pkg::REG_W-1:0]  rs1_data;
	logic [rv_alu_pkg::REG_W-1:0]  rs2_data;
	rv_alu_pkg::fwd_src_e          rs1_src;
	rv_alu_pkg::fwd_src_e          rs2_src;
	rv_alu_pkg::op1_src_e          op1_src;
	rv_alu_pkg::op2_src_e          op2_src;
	rv_alu_pkg::alu_op_e           alu_op;
	logic                          pc_src;
	logic                          is_jump;
	rv_isa_pkg::reg_idx_t          rd;
	logic                          wen;

	modport src (output valid, pc, imm, rs1_data, rs2_data, rs1_src, rs2_src,
		op1_src, op2_src, alu_op, pc_src, is_jump, rd, wen);
	modport dst (input valid, pc, imm, rs1_data, rs2_data, rs1_src, rs2_src,
		op1_src, op2_src, alu_op, pc_src, is_jump, rd, wen);
endinterface

// Execute results handed to the commit stage.
interface ex_cm_if;
	logic                          valid;
	rv_isa_pkg::reg_idx_t          rd;
	logic                          wen;
	logic [rv_alu_pkg::REG_W-1:0]  alu_result;
	logic                          taken;
	logic [rv_alu_pkg::REG_W-1:0]  target;

	modport src (output valid, rd, wen, alu_result, taken, target);
	modport dst (input valid, rd, wen, alu_result, taken, target);
endinterface

// The EX/MEM and MEM/WB levels, seen as forwarding sources.
interface fwd_if;
	logic                          me_valid;
	rv_isa_pkg::reg_idx_t          me_rd;
	logic                          me_wen;
	logic [rv_alu_pkg::REG_W-1:0]  me_alu_result;
	logic                          wb_valid;
	rv_isa_pkg::reg_idx_t          wb_rd;
	logic                          wb_wen;
	logic [rv_alu_pkg::REG_W-1:0]  wb_rd_data;

	modport src (output me_valid, me_rd, me_wen, me_alu_result,
		wb_valid, wb_rd, wb_wen, wb_rd_data);
	modport ctl (input me_rd, me_wen);
	modport dat (input me_alu_result, wb_rd_data);
endinterface

// File: hw/rv_exec_top.sv
`timescale 1ns/1ps

module rv_exec_top (
	input  logic         clk,
	input  logic         reset,
	input  logic         in_valid,
	input  logic [31:0]  in_instr,
	input  logic [63:0]  in_pc,
	output logic         ret_valid,
	output logic [4:0]   ret_rd,
	output logic         ret_wen,
	output logic [63:0]  ret_data,
	output logic         ret_taken,
	output logic [63:0]  ret_target
);

	rv_isa_pkg::reg_idx_t          rs1;
	rv_isa_pkg::reg_idx_t          rs2;
	logic [rv_alu_pkg::REG_W-1:0]  rs1_data;
	logic [rv_alu_pkg::REG_W-1:0]  rs2_data;
	logic                          rf_we;
	rv_isa_pkg::reg_idx_t          rf_wa;
	logic [rv_alu_pkg::REG_W-1:0]  rf_wd;

	id_ex_if u_id_ex ();
	ex_cm_if u_ex_cm ();
	fwd_if   u_fwd ();

	regfile u_regfile (
		.clk      (clk),
		.reset    (reset),
		.rs1      (rs1),
		.rs2      (rs2),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.we       (rf_we),
		.wa       (rf_wa),
		.wd       (rf_wd)
	);

	id_stage u_id_stage (
		.clk      (clk),
		.reset    (reset),
		.in_valid (in_valid),
		.in_instr (in_instr),
		.in_pc    (in_pc),
		.rs1      (rs1),
		.rs2      (rs2),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.ex       (u_id_ex.src),
		.fwd      (u_fwd.ctl)
	);

	exe_stage u_exe_stage (
		.ex  (u_id_ex.dst),
		.fwd (u_fwd.dat),
		.cm  (u_ex_cm.src)
	);

	commit_stage u_commit_stage (
		.clk        (clk),
		.reset      (reset),
		.cm         (u_ex_cm.dst),
		.fwd        (u_fwd.src),
		.rf_we      (rf_we),
		.rf_wa      (rf_wa),
		.rf_wd      (rf_wd),
		.ret_valid  (ret_valid),
		.ret_rd     (ret_rd),
		.ret_wen    (ret_wen),
		.ret_data   (ret_data),
		.ret_taken  (ret_taken),
		.ret_target (ret_target)
	);

endmodule

// File: hw/rv_isa_pkg.sv
package rv_isa_pkg;

	// Register index into the integer register file.
	typedef logic [4:0] reg_idx_t;

	// Major opcodes handled by the execute pipeline.
	localparam logic [6:0] OPC_OP        = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
	localparam logic [6:0] OPC_OP_32     = 7'b0111011;
	localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
	localparam logic [6:0] OPC_LUI       = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
	localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
	localparam logic [6:0] OPC_JAL       = 7'b1101111;
	localparam logic [6:0] OPC_JALR      = 7'b1100111;

	typedef struct packed {
		logic [6:0] funct7;
		reg_idx_t   rs2;
		reg_idx_t   rs1;
		logic [2:0] funct3;
		reg_idx_t   rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		reg_idx_t    rs1;
		logic [2:0]  funct3;
		reg_idx_t    rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	// In the branch format the rd slot carries the low immediate bits.
	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		reg_idx_t   rs2;
		reg_idx_t   rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm;
		reg_idx_t    rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		reg_idx_t   rd;
		logic [6:0] opcode;
	} j_fmt_t;

	// One instruction word seen through every encoding format.
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} instr_u;

endpackage

// File: rv_exec_top.f
hw/rv_isa_pkg.sv
hw/rv_alu_pkg.sv
hw/rv_exec_if.sv
hw/regfile.sv
hw/id_stage.sv
hw/exe_stage.sv
hw/commit_stage.sv
hw/rv_exec_top.sv
sim/rv_exec_chk.sv
sim/rv_exec_tb.sv

// File: sim/rv_exec_chk.sv
`timescale 1ns/1ps

module rv_exec_chk (
	input logic         clk,
	input logic         reset,
	input logic         in_valid,
	input logic [31:0]  in_instr,
	input logic         ret_valid,
	input logic [4:0]   ret_rd,
	input logic         ret_wen,
	input logic [63:0]  ret_target
);

	logic jalr_in;

	assign jalr_in = in_valid && in_instr[6:0] == rv_isa_pkg::OPC_JALR;

	// The first cycle out of reset shows an empty pipeline.
	quiet_after_reset: assert property (@(posedge clk) $fell(reset) |-> !ret_valid && !ret_wen)
		else $error("Retire outputs active right after reset");

	// Every sampled instruction retires exactly three cycles later.
	retire_follows_issue: assert property (@(posedge clk) disable iff (reset)
		!$past(reset, 3) |-> ret_valid == $past(in_valid, 3))
		else $error("ret_valid does not follow in_valid by three cycles");

	no_write_to_x0: assert property (@(posedge clk) disable iff (reset)
		ret_wen |-> ret_rd != 5'd0)
		else $error("Register write aimed at x0");

	jalr_target_even: assert property (@(posedge clk) disable iff (reset)
		$past(jalr_in, 3) |-> !ret_target[0])
		else $error("JALR target has bit 0 set");

endmodule

bind rv_exec_top rv_exec_chk u_rv_exec_chk (
	.clk        (clk),
	.reset      (reset),
	.in_valid   (in_valid),
	.in_instr   (in_instr),
	.ret_valid  (ret_valid),
	.ret_rd     (ret_rd),
	.ret_wen    (ret_wen),
	.ret_target (ret_target)
);

// File: sim/rv_exec_tb.sv
`timescale 1ns/1ps

module rv_exec_tb;

	typedef struct packed {
		logic [4:0]   rd;
		logic         wen;
		logic [63:0]  data;
		logic         taken;
		logic [63:0]  target;
	} exp_ret_t;

	logic         clk = 1'b0;
	logic         reset;
	logic         in_valid;
	logic [31:0]  in_instr;
	logic [63:0]  in_pc;
	logic         ret_valid;
	logic [4:0]   ret_rd;
	logic         ret_wen;
	logic [63:0]  ret_data;
	logic         ret_taken;
	logic [63:0]  ret_target;

	logic [rv_alu_pkg::REG_W-1:0]  model_rf [0:31];
	logic [rv_alu_pkg::REG_W-1:0]  pc;
	exp_ret_t                      exp_q [$];
	int                            sent;
	int                            retired;

	rv_exec_top u_rv_exec_top (
		.clk        (clk),
		.reset      (reset),
		.in_valid   (in_valid),
		.in_instr   (in_instr),
		.in_pc      (in_pc),
		.ret_valid  (ret_valid),
		.ret_rd     (ret_rd),
		.ret_wen    (ret_wen),
		.ret_data   (ret_data),
		.ret_taken  (ret_taken),
		.ret_target (ret_target)
	);

	initial begin
		forever #50 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [63:0] got,
		input logic [63:0] want);
		abort_run($sformatf("Mismatch on %s: got 0x%h, expected 0x%h", name, got, want));
	endtask

	function automatic logic [63:0] sext_word(input logic [31:0] v);
		return {{32{v[31]}}, v};
	endfunction

	function automatic rv_isa_pkg::instr_u enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		rv_isa_pkg::instr_u w;
		w.r = '{f7, rs2, rs1, f3, rd, opc};
		return w;
	endfunction

	function automatic rv_isa_pkg::instr_u enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		rv_isa_pkg::instr_u w;
		w.i = '{imm, rs1, f3, rd, opc};
		return w;
	endfunction

	function automatic rv_isa_pkg::instr_u enc_b(input logic [12:0] off, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		rv_isa_pkg::instr_u w;
		w.b = '{off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_isa_pkg::OPC_BRANCH};
		return w;
	endfunction

	function automatic rv_isa_pkg::instr_u enc_u(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] opc);
		rv_isa_pkg::instr_u w;
		w.u = '{imm, rd, opc};
		return w;
	endfunction

	function automatic rv_isa_pkg::instr_u enc_j(input logic [20:0] off, input logic [4:0] rd);
		rv_isa_pkg::instr_u w;
		w.j = '{off[20], off[10:1], off[11], off[19:12], rd, rv_isa_pkg::OPC_JAL};
		return w;
	endfunction

	// Predicts the retirement from the ISA rules, then drives the word.
	task automatic send(input rv_isa_pkg::instr_u w);
		exp_ret_t     e;
		logic [31:0]  ir;
		logic [63:0]  a;
		logic [63:0]  b;
		logic [63:0]  imm_i;
		logic [63:0]  imm_b;
		logic [63:0]  imm_u;
		logic [63:0]  imm_j;
		logic [31:0]  lo;
		logic [6:0]   opc;
		logic [2:0]   f3;
		logic         alt;
		// Fields come from the bit positions of the base ISA encoding.
		ir    = w;
		opc   = ir[6:0];
		a     = model_rf[ir[19:15]];
		b     = model_rf[ir[24:20]];
		imm_i = {{52{ir[31]}}, ir[31:20]};
		imm_b = {{52{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
		imm_u = {{32{ir[31]}}, ir[31:12], 12'b0};
		imm_j = {{44{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
		f3    = ir[14:12];
		alt   = ir[30];
		lo    = '0;
		e     = '{rd: ir[11:7], wen: 1'b1, data: '0, taken: 1'b0, target: '0};
		case (opc)
			rv_isa_pkg::OPC_OP, rv_isa_pkg::OPC_OP_IMM: begin
				if (opc == rv_isa_pkg::OPC_OP_IMM) begin
					b = imm_i;
					alt = alt && f3 == 3'd5;
				end
				case (f3)
					3'd0: e.data = alt ? a - b : a + b;
					3'd1: e.data = a << b[5:0];
					3'd2: e.data = 64'($signed(a) < $signed(b));
					3'd3: e.data = 64'(a < b);
					3'd4: e.data = a ^ b;
					3'd5: begin
						if (alt)
							e.data = $signed(a) >>> b[5:0];
						else
							e.data = a >> b[5:0];
					end
					3'd6: e.data = a | b;
					default: e.data = a & b;
				endcase
			end
			rv_isa_pkg::OPC_OP_32, rv_isa_pkg::OPC_OP_IMM_32: begin
				if (opc == rv_isa_pkg::OPC_OP_IMM_32) begin
					b = imm_i;
					alt = alt && f3 == 3'd5;
				end
				case (f3)
					3'd0: lo = alt ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
					3'd1: lo = a[31:0] << b[4:0];
					3'd5: begin
						if (alt)
							lo = $signed(a[31:0]) >>> b[4:0];
						else
							lo = a[31:0] >> b[4:0];
					end
					default: e.wen = 1'b0;
				endcase
				e.data = sext_word(lo);
			end
			rv_isa_pkg::OPC_LUI: e.data = imm_u;
			rv_isa_pkg::OPC_AUIPC: e.data = pc + imm_u;
			rv_isa_pkg::OPC_BRANCH: begin
				e.wen = 1'b0;
				e.target = pc + imm_b;
				case (f3)
					3'd0: e.taken = a == b;
					3'd1: e.taken = a != b;
					3'd4: e.taken = $signed(a) < $signed(b);
					3'd5: e.taken = $signed(a) >= $signed(b);
					3'd6: e.taken = a < b;
					3'd7: e.taken = a >= b;
					default: e.taken = 1'b0;
				endcase
			end
			rv_isa_pkg::OPC_JAL: begin
				e.data = pc + 64'd4;
				e.taken = 1'b1;
				e.target = pc + imm_j;
			end
			rv_isa_pkg::OPC_JALR: begin
				e.data = pc + 64'd4;
				e.taken = 1'b1;
				e.target = (a + imm_i) & ~64'd1;
			end
			default: e.wen = 1'b0;
		endcase
		if (e.rd == 5'd0)
			e.wen = 1'b0;
		if (e.wen)
			model_rf[e.rd] = e.data;
		@(negedge clk);
		in_valid = 1'b1;
		in_instr = w;
		in_pc    = pc;
		exp_q.push_back(e);
		sent++;
		pc = pc + 64'd4;
	endtask

	task automatic go_idle();
		@(negedge clk);
		in_valid = 1'b0;
		in_instr = '0;
	endtask

	// Fills every register with a wide value through a dependent chain.
	task automatic seed_regs();
		for (int r = 1; r < 32; r++) begin
			send(enc_u(20'($urandom), 5'(r), rv_isa_pkg::OPC_LUI));
			send(enc_i(12'($urandom), 5'(r), 3'd0, 5'(r), rv_isa_pkg::OPC_OP_IMM));
			send(enc_i({6'd0, 6'($urandom_range(31, 8))}, 5'(r), 3'd1, 5'(r),
				rv_isa_pkg::OPC_OP_IMM));
			send(enc_r(7'd0, 5'(r - 1), 5'(r), 3'd4, 5'(r), rv_isa_pkg::OPC_OP));
		end
	endtask

	task automatic run_alu_mix(input int n);
		logic [2:0]   f3;
		logic         alt;
		logic [11:0]  imm;
		logic [4:0]   rd;
		logic [4:0]   rs1;
		logic [4:0]   rs2;
		for (int k = 0; k < n; k++) begin
			f3  = 3'($urandom);
			alt = 1'($urandom) && (f3 == 3'd0 || f3 == 3'd5);
			rd  = 5'($urandom_range(31, 1));
			rs1 = 5'($urandom);
			rs2 = 5'($urandom);
			imm = 12'($urandom);
			if (f3 == 3'd1)
				imm = {6'd0, imm[5:0]};
			else if (f3 == 3'd5)
				imm = {1'b0, alt, 4'd0, imm[5:0]};
			case ($urandom_range(5, 0))
				0, 1: send(enc_r({1'b0, alt, 5'd0}, rs2, rs1, f3, rd, rv_isa_pkg::OPC_OP));
				2, 3: send(enc_i(imm, rs1, f3, rd, rv_isa_pkg::OPC_OP_IMM));
				4: send(enc_u(20'($urandom), rd, rv_isa_pkg::OPC_LUI));
				default: send(enc_u(20'($urandom), rd, rv_isa_pkg::OPC_AUIPC));
			endcase
		end
	endtask

	// A producer, d-1 unrelated fillers, then consumers at distance d and d+1.
	task automatic run_fwd_chains();
		logic [4:0] a;
		logic [4:0] b;
		for (int d = 1; d <= 3; d++) begin
			for (int k = 0; k < 12; k++) begin
				a = 5'($urandom_range(30, 1));
				b = a + 5'd1;
				send(enc_i(12'($urandom), a, 3'd0, a, rv_isa_pkg::OPC_OP_IMM));
				for (int f = 1; f < d; f++) begin
					send(enc_i(12'($urandom), b, 3'd0, b, rv_isa_pkg::OPC_OP_IMM));
				end
				send(enc_r({1'b0, 1'($urandom), 5'd0}, b, a, 3'd0, b, rv_isa_pkg::OPC_OP));
				send(enc_r(7'd0, a, 5'd0, 3'd6, b, rv_isa_pkg::OPC_OP));
			end
		end
	endtask

	// Operands x10 to x13 all have bit 31 set and random low bits for shift amounts.
	task automatic run_word_ops();
		logic [2:0]   f3;
		logic         alt;
		logic [11:0]  imm;
		for (int r = 10; r < 14; r++) begin
			send(enc_u({1'b1, 19'($urandom)}, 5'(r), rv_isa_pkg::OPC_LUI));
			send(enc_i({1'b0, 11'($urandom)}, 5'(r), 3'd6, 5'(r), rv_isa_pkg::OPC_OP_IMM));
		end
		for (int k = 0; k < 40; k++) begin
			case ($urandom_range(2, 0))
				0: f3 = 3'd0;
				1: f3 = 3'd1;
				default: f3 = 3'd5;
			endcase
			alt = 1'($urandom) && f3 != 3'd1;
			imm = (f3 == 3'd0) ? 12'($urandom) : {1'b0, alt, 5'd0, 5'($urandom)};
			if (1'($urandom))
				send(enc_r({1'b0, alt, 5'd0}, 5'($urandom_range(13, 10)),
					5'($urandom_range(13, 10)), f3, 5'($urandom_range(19, 14)),
					rv_isa_pkg::OPC_OP_32));
			else
				send(enc_i(imm, 5'($urandom_range(13, 10)), f3, 5'($urandom_range(19, 14)),
					rv_isa_pkg::OPC_OP_IMM_32));
		end
	endtask

	// Each branch kind sees an equal pair, a negative-positive pair and the reverse.
	task automatic run_branches();
		logic [19:0] neg;
		logic [19:0] pos;
		for (int f = 0; f < 8; f++) begin
			if (f != 2 && f != 3) begin
				for (int p = 0; p < 3; p++) begin
					neg = {1'b1, 19'($urandom)};
					pos = {1'b0, 19'($urandom)};
					send(enc_u((p == 2) ? pos : neg, 5'd20, rv_isa_pkg::OPC_LUI));
					send(enc_u((p == 1) ? pos : neg, 5'd21, rv_isa_pkg::OPC_LUI));
					send(enc_b({12'($urandom), 1'b0}, 5'd21, 5'd20, 3'(f)));
				end
			end
		end
	endtask

	task automatic run_jumps();
		for (int k = 0; k < 8; k++) begin
			send(enc_j({20'($urandom), 1'b0}, 5'($urandom_range(31, 1))));
			send(enc_u(20'($urandom), 5'd22, rv_isa_pkg::OPC_LUI));
			send(enc_i(12'($urandom), 5'd22, 3'd0, 5'd22, rv_isa_pkg::OPC_OP_IMM));
			send(enc_i(12'($urandom), 5'd22, 3'd0, 5'($urandom_range(31, 1)),
				rv_isa_pkg::OPC_JALR));
		end
	endtask

	task automatic run_x0();
		for (int k = 0; k < 6; k++) begin
			send(enc_i(12'($urandom), 5'($urandom_range(31, 1)), 3'd0, 5'd0,
				rv_isa_pkg::OPC_OP_IMM));
		end
		send(enc_u(20'($urandom), 5'd0, rv_isa_pkg::OPC_LUI));
		send(enc_j(21'd8, 5'd0));
		send(enc_r(7'd0, 5'd0, 5'd0, 3'd0, 5'd5, rv_isa_pkg::OPC_OP));
		send(enc_i(12'($urandom), 5'd0, 3'd6, 5'd6, rv_isa_pkg::OPC_OP_IMM));
		// A load opcode is not supported and must retire without a write.
		send(enc_i(12'($urandom), 5'd1, 3'd3, 5'd7, 7'b0000011));
	endtask

	always @(negedge clk) begin
		exp_ret_t e;
		if (reset || !ret_valid) begin
			assert (!ret_valid && !ret_wen)
				else abort_run("Retire outputs active during reset or without a valid retire.");
		end else if (exp_q.size() == 0) begin
			abort_run("An instruction retired that was never sent.");
		end else begin
			e = exp_q.pop_front();
			retired++;
			assert (ret_wen == e.wen) else report_mismatch("ret_wen", 64'(ret_wen), 64'(e.wen));
			assert (ret_taken == e.taken)
				else report_mismatch("ret_taken", 64'(ret_taken), 64'(e.taken));
			if (e.wen) begin
				assert (ret_rd == e.rd) else report_mismatch("ret_rd", 64'(ret_rd), 64'(e.rd));
				assert (ret_data == e.data) else report_mismatch("ret_data", ret_data, e.data);
			end
			if (e.taken) begin
				assert (ret_target == e.target)
					else report_mismatch("ret_target", ret_target, e.target);
			end
		end
	end

	initial begin
		int n;
		void'($urandom(53));
		reset    = 1'b1;
		in_valid = 1'b0;
		in_instr = '0;
		in_pc    = '0;
		sent     = 0;
		retired  = 0;
		pc       = {32'($urandom), 32'($urandom) & 32'hFFFF_FFFC};
		for (int i = 0; i < 32; i++) begin
			model_rf[i] = '0;
		end
		repeat (2) @(negedge clk);
		reset = 1'b0;
		repeat (3) go_idle();
		seed_regs();
		run_alu_mix(200);
		run_fwd_chains();
		run_word_ops();
		run_branches();
		run_jumps();
		run_x0();
		go_idle();
		n = 0;
		while (retired != sent && n < 20) begin
			@(negedge clk);
			n++;
		end
		if (retired == sent) begin
			$display("Everything OK");
			$finish;
		end else begin
			abort_run("Timed out waiting for the pipeline to drain.");
		end
	end

endmodule
